/* list.f */
src/corebus_pkg.sv
src/corebus_hold_checker.sv
src/corebus_write_checker.sv
src/corebus_outstanding_table.sv
src/corebus_response_checker.sv
src/corebus_monitor.sv
sim/tb_corebus_monitor.sv

/* run_sim.sh */
#!/bin/sh
# Build the corebus monitor testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_corebus_monitor -o tb_corebus_monitor \
  -f list.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed"
  exit 1
fi

./obj_dir/tb_corebus_monitor > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "ERRORS FOUND" "$SIM_LOG"; then
  echo "run failed"
  exit 1
fi
echo "run passed"
exit 0

/* sim/tb_corebus_monitor.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// corebus monitor testbench
// table driven bus scenarios, checks the
// error pulses and the sticky status.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_corebus_monitor;
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [1:0] {H_NONE, H_CMD, H_DATA, H_RESP} hold_e;

  typedef struct packed {
    corebus_pkg::corebus_cmd_e       kind;
    logic [corebus_pkg::ID_W-1:0]    id;
    logic [corebus_pkg::LEN_W-1:0]   len;
    logic [corebus_pkg::BEAT_W-1:0]  wbeats;      // write data beats sent.
    logic                            data_first;
    logic [corebus_pkg::BEAT_W-1:0]  rbeats;      // response beats returned.
    logic [corebus_pkg::ID_W-1:0]    id_off;
    logic                            flip_kind;   // response of the wrong kind.
    logic [1:0]                      max_stall;
    hold_e                           hold;
    corebus_pkg::corebus_err_t       exp;
  } row_t;

  localparam int NUM_ROWS       = 20;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 60;

  localparam corebus_pkg::corebus_cmd_e RD  = corebus_pkg::COREBUS_READ;
  localparam corebus_pkg::corebus_cmd_e WR  = corebus_pkg::COREBUS_WRITE;
  localparam corebus_pkg::corebus_cmd_e WNP = corebus_pkg::COREBUS_WRITE_NP;

  // bit order hold_cmd, hold_data, hold_resp, write_count, resp_unknown, resp_count.
  localparam corebus_pkg::corebus_err_t E_NONE  = 6'b000000;
  localparam corebus_pkg::corebus_err_t E_HCMD  = 6'b100000;
  localparam corebus_pkg::corebus_err_t E_HDATA = 6'b010000;
  localparam corebus_pkg::corebus_err_t E_HRESP = 6'b001000;
  localparam corebus_pkg::corebus_err_t E_WCNT  = 6'b000100;
  localparam corebus_pkg::corebus_err_t E_RUNK  = 6'b000010;
  localparam corebus_pkg::corebus_err_t E_RCNT  = 6'b000001;

  logic                        clk = 1'b0;
  logic                        i_rst_n;
  logic                        i_cmd_valid;
  corebus_pkg::corebus_cmd_t   i_cmd;
  logic                        i_cmd_accept;
  logic                        i_wdata_valid;
  corebus_pkg::corebus_wdata_t i_wdata;
  logic                        i_wdata_accept;
  logic                        i_resp_valid;
  corebus_pkg::corebus_resp_t  i_resp;
  logic                        i_resp_accept;
  logic                        i_clr_status;
  corebus_pkg::corebus_err_t   o_err;
  corebus_pkg::corebus_err_t   o_err_status;

  row_t                        rows [NUM_ROWS];
  corebus_pkg::corebus_err_t   seen;
  integer                      seed = 32'h6e4b;
  int                          errors = 0;
  int                          checks = 0;
  int                          cycles = 0;

  corebus_monitor dut0 (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_cmd_valid    (i_cmd_valid),
    .i_cmd          (i_cmd),
    .i_cmd_accept   (i_cmd_accept),
    .i_wdata_valid  (i_wdata_valid),
    .i_wdata        (i_wdata),
    .i_wdata_accept (i_wdata_accept),
    .i_resp_valid   (i_resp_valid),
    .i_resp         (i_resp),
    .i_resp_accept  (i_resp_accept),
    .i_clr_status   (i_clr_status),
    .o_err          (o_err),
    .o_err_status   (o_err_status)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic row_t make_row(
    input corebus_pkg::corebus_cmd_e      kind,
    input logic [corebus_pkg::ID_W-1:0]   id,
    input logic [corebus_pkg::LEN_W-1:0]  len,
    input logic [corebus_pkg::BEAT_W-1:0] wbeats,
    input logic                           data_first,
    input logic [corebus_pkg::BEAT_W-1:0] rbeats,
    input logic [corebus_pkg::ID_W-1:0]   id_off,
    input logic                           flip_kind,
    input logic [1:0]                     max_stall,
    input hold_e                          hold,
    input corebus_pkg::corebus_err_t      exp
  );
    row_t r;
    r.kind       = kind;
    r.id         = id;
    r.len        = len;
    r.wbeats     = wbeats;
    r.data_first = data_first;
    r.rbeats     = rbeats;
    r.id_off     = id_off;
    r.flip_kind  = flip_kind;
    r.max_stall  = max_stall;
    r.hold       = hold;
    r.exp        = exp;
    return r;
  endfunction

  // reads get data responses, non-posted writes plain ones.
  function automatic corebus_pkg::corebus_resp_e resp_kind_for(input row_t r);
    corebus_pkg::corebus_resp_e k;
    k = (r.kind == RD) ? corebus_pkg::COREBUS_RESP_DATA : corebus_pkg::COREBUS_RESP;
    if (r.flip_kind) begin
      k = (k == corebus_pkg::COREBUS_RESP) ? corebus_pkg::COREBUS_RESP_DATA
                                           : corebus_pkg::COREBUS_RESP;
    end
    return k;
  endfunction

  task automatic pick_stall(input int max_stall, output int n);
    n = $unsigned($random(seed)) % (max_stall + 1);
  endtask

  // one falling edge, pulses gathered where o_err is stable.
  task automatic next_cycle();
    @(negedge clk);
    seen = corebus_pkg::corebus_err_t'(seen | o_err);
  endtask

  task automatic drive_command(input row_t r);
    int stall;
    corebus_pkg::corebus_cmd_t c;
    pick_stall(int'(r.max_stall), stall);
    if (r.hold == H_CMD && stall < 1) begin
      stall = 1;
    end
    c.kind = r.kind;
    c.id   = r.id;
    c.addr = 16'($random(seed));
    c.len  = r.len;
    i_cmd        = c;
    i_cmd_valid  = 1'b1;
    i_cmd_accept = 1'b0;
    for (int k = 0; k < stall; k++) begin
      next_cycle();
      if (r.hold == H_CMD && k == 0) begin
        i_cmd.addr = ~i_cmd.addr;  // address moves mid-stall.
      end
    end
    i_cmd_accept = 1'b1;
    next_cycle();
    i_cmd_valid  = 1'b0;
    i_cmd_accept = 1'b0;
  endtask

  task automatic send_write_burst(input row_t r);
    int stall;
    corebus_pkg::corebus_wdata_t w;
    for (int b = 0; b < int'(r.wbeats); b++) begin
      pick_stall(int'(r.max_stall), stall);
      if (r.hold == H_DATA && b == 0 && stall < 2) begin
        stall = 2;
      end
      w.data = 32'($random(seed));
      w.be   = '1;
      w.last = (b == int'(r.wbeats) - 1);
      i_wdata        = w;
      i_wdata_valid  = 1'b1;
      i_wdata_accept = 1'b0;
      for (int k = 0; k < stall; k++) begin
        next_cycle();
        if (r.hold == H_DATA && b == 0) begin
          i_wdata_valid = (k != 0);  // valid gone for one cycle.
        end
      end
      i_wdata_accept = 1'b1;
      next_cycle();
      i_wdata_valid  = 1'b0;
      i_wdata_accept = 1'b0;
    end
  endtask

  task automatic return_response(input row_t r);
    int stall;
    corebus_pkg::corebus_resp_t p;
    for (int b = 0; b < int'(r.rbeats); b++) begin
      pick_stall(int'(r.max_stall), stall);
      if (r.hold == H_RESP && b == 0 && stall < 1) begin
        stall = 1;
      end
      p.kind = resp_kind_for(r);
      p.id   = r.id + r.id_off;  // wraps over the 8 ids.
      p.data = 32'($random(seed));
      p.last = (b == int'(r.rbeats) - 1);
      i_resp        = p;
      i_resp_valid  = 1'b1;
      i_resp_accept = 1'b0;
      for (int k = 0; k < stall; k++) begin
        next_cycle();
        if (r.hold == H_RESP && b == 0 && k == 0) begin
          i_resp.data = ~i_resp.data;
        end
      end
      i_resp_accept = 1'b1;
      next_cycle();
      i_resp_valid  = 1'b0;
      i_resp_accept = 1'b0;
    end
  endtask

  initial begin
    row_t r;
    i_rst_n        = 1'b0;
    i_cmd_valid    = 1'b0;
    i_cmd          = '0;
    i_cmd_accept   = 1'b0;
    i_wdata_valid  = 1'b0;
    i_wdata        = '0;
    i_wdata_accept = 1'b0;
    i_resp_valid   = 1'b0;
    i_resp         = '0;
    i_resp_accept  = 1'b0;
    i_clr_status   = 1'b0;
    seen           = '0;

    // legal traffic first.
    rows[0]  = make_row(RD,  3'd0, 4'd4, 5'd0,  1'b0, 5'd4,  3'd0, 1'b0, 2'd2, H_NONE, E_NONE);
    rows[1]  = make_row(WR,  3'd1, 4'd3, 5'd3,  1'b0, 5'd0,  3'd0, 1'b0, 2'd2, H_NONE, E_NONE);
    rows[2]  = make_row(WR,  3'd2, 4'd2, 5'd2,  1'b1, 5'd0,  3'd0, 1'b0, 2'd2, H_NONE, E_NONE);
    rows[3]  = make_row(WNP, 3'd3, 4'd1, 5'd1,  1'b0, 5'd1,  3'd0, 1'b0, 2'd2, H_NONE, E_NONE);
    rows[4]  = make_row(WNP, 3'd4, 4'd4, 5'd4,  1'b1, 5'd1,  3'd0, 1'b0, 2'd2, H_NONE, E_NONE);
    rows[5]  = make_row(WR,  3'd5, 4'd0, 5'd16, 1'b0, 5'd0,  3'd0, 1'b0, 2'd1, H_NONE, E_NONE);
    rows[6]  = make_row(RD,  3'd2, 4'd0, 5'd0,  1'b0, 5'd16, 3'd0, 1'b0, 2'd1, H_NONE, E_NONE);
    rows[7]  = make_row(RD,  3'd0, 4'd2, 5'd0,  1'b0, 5'd2,  3'd0, 1'b0, 2'd2, H_CMD,  E_HCMD);
    rows[8]  = make_row(WR,  3'd1, 4'd2, 5'd2,  1'b0, 5'd0,  3'd0, 1'b0, 2'd2, H_DATA, E_HDATA);
    rows[9]  = make_row(RD,  3'd3, 4'd2, 5'd0,  1'b0, 5'd2,  3'd0, 1'b0, 2'd2, H_RESP, E_HRESP);
    rows[10] = make_row(WR,  3'd4, 4'd3, 5'd2,  1'b0, 5'd0,  3'd0, 1'b0, 2'd2, H_NONE, E_WCNT);
    rows[11] = make_row(WNP, 3'd5, 4'd2, 5'd3,  1'b1, 5'd1,  3'd0, 1'b0, 2'd2, H_NONE, E_WCNT);
    rows[12] = make_row(WR,  3'd6, 4'd0, 5'd15, 1'b0, 5'd0,  3'd0, 1'b0, 2'd1, H_NONE, E_WCNT);
    rows[13] = make_row(WR,  3'd7, 4'd1, 5'd1,  1'b0, 5'd1,  3'd0, 1'b0, 2'd2, H_NONE, E_RUNK);
    rows[14] = make_row(WNP, 3'd6, 4'd1, 5'd1,  1'b0, 5'd1,  3'd0, 1'b1, 2'd2, H_NONE, E_RUNK);
    rows[15] = make_row(RD,  3'd0, 4'd4, 5'd0,  1'b0, 5'd3,  3'd0, 1'b0, 2'd2, H_NONE, E_RCNT);
    rows[16] = make_row(RD,  3'd3, 4'd2, 5'd0,  1'b0, 5'd3,  3'd0, 1'b0, 2'd2, H_NONE, E_RCNT);
    rows[17] = make_row(WNP, 3'd4, 4'd1, 5'd1,  1'b0, 5'd2,  3'd0, 1'b0, 2'd2, H_NONE, E_RCNT);
    rows[18] = make_row(WR,  3'd5, 4'd2, 5'd3,  1'b0, 5'd0,  3'd0, 1'b0, 2'd2, H_DATA,
                        6'b010100);
    // leaves id 1 outstanding, so it stays last.
    rows[19] = make_row(RD,  3'd1, 4'd1, 5'd0,  1'b0, 5'd1,  3'd1, 1'b0, 2'd2, H_NONE, E_RUNK);

    repeat (4) next_cycle();
    i_rst_n = 1'b1;
    next_cycle();
    checks++;
    assert (o_err == '0 && o_err_status == '0) else begin
      errors++;
      $display("FAIL o_err/o_err_status after reset: got %h/%h, expected 00/00",
               o_err, o_err_status);
    end

    for (int i = 0; i < NUM_ROWS; i++) begin
      r    = rows[i];
      seen = '0;
      if (r.data_first) begin
        send_write_burst(r);
        drive_command(r);
      end else begin
        drive_command(r);
        send_write_burst(r);
      end
      return_response(r);
      repeat (3) next_cycle();

      checks++;
      assert (seen == r.exp) else begin
        errors++;
        $display("FAIL o_err row %0d: got %h, expected %h", i, seen, r.exp);
      end
      checks++;
      assert (o_err_status == r.exp) else begin
        errors++;
        $display("FAIL o_err_status row %0d: got %h, expected %h", i, o_err_status, r.exp);
      end

      i_clr_status = 1'b1;
      next_cycle();
      i_clr_status = 1'b0;
      next_cycle();
      checks++;
      assert (o_err_status == '0) else begin
        errors++;
        $display("FAIL o_err_status row %0d after clear: got %h, expected 00",
                 i, o_err_status);
      end
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/corebus_hold_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// corebus hold checker
// flags valid or payload changing
// while a beat waits for accept.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module corebus_hold_checker #(
  parameter type payload_t = logic
) (
  input  var logic     clk,
  input  var logic     i_rst_n,
  input  var logic     i_valid,
  input  var logic     i_accept,
  input  var payload_t i_payload,
  output logic         o_violation
);

  logic     waiting;
  payload_t prev_payload;

  // armed by a stalled beat.
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      waiting <= 1'b0;
    end else begin
      waiting <= i_valid && !i_accept;
    end
  end

  always_ff @(posedge clk) begin
    prev_payload <= i_payload;
  end

  // valid dropped or payload moved during the stall.
  assign o_violation = waiting && (!i_valid || (i_payload != prev_payload));

endmodule

`default_nettype wire

/* src/corebus_monitor.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// corebus monitor
// passive protocol monitor, registered
// error pulses and sticky status.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module corebus_monitor (
  input  var logic                        clk,
  input  var logic                        i_rst_n,
  input  var logic                        i_cmd_valid,
  input  var corebus_pkg::corebus_cmd_t   i_cmd,
  input  var logic                        i_cmd_accept,
  input  var logic                        i_wdata_valid,
  input  var corebus_pkg::corebus_wdata_t i_wdata,
  input  var logic                        i_wdata_accept,
  input  var logic                        i_resp_valid,
  input  var corebus_pkg::corebus_resp_t  i_resp,
  input  var logic                        i_resp_accept,
  input  var logic                        i_clr_status,
  output corebus_pkg::corebus_err_t       o_err,
  output corebus_pkg::corebus_err_t       o_err_status
);

  logic                           cmd_fire;
  logic                           wdata_fire;
  logic                           resp_fire;
  logic                           hold_cmd;
  logic                           hold_data;
  logic                           hold_resp;
  logic                           write_count;
  logic                           resp_known;
  logic [corebus_pkg::BEAT_W-1:0] resp_expected;
  logic                           resp_unknown;
  logic                           resp_count;
  corebus_pkg::corebus_err_t      err_now;

  assign cmd_fire   = i_cmd_valid && i_cmd_accept;
  assign wdata_fire = i_wdata_valid && i_wdata_accept;
  assign resp_fire  = i_resp_valid && i_resp_accept;

  corebus_hold_checker #(
    .payload_t (corebus_pkg::corebus_cmd_t)
  ) u_hold_cmd (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (i_cmd_valid),
    .i_accept    (i_cmd_accept),
    .i_payload   (i_cmd),
    .o_violation (hold_cmd)
  );

  corebus_hold_checker #(
    .payload_t (corebus_pkg::corebus_wdata_t)
  ) u_hold_wdata (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (i_wdata_valid),
    .i_accept    (i_wdata_accept),
    .i_payload   (i_wdata),
    .o_violation (hold_data)
  );

  corebus_hold_checker #(
    .payload_t (corebus_pkg::corebus_resp_t)
  ) u_hold_resp (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (i_resp_valid),
    .i_accept    (i_resp_accept),
    .i_payload   (i_resp),
    .o_violation (hold_resp)
  );

  corebus_write_checker u_write_checker (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_cmd_fire    (cmd_fire),
    .i_cmd         (i_cmd),
    .i_wdata_fire  (wdata_fire),
    .i_wdata       (i_wdata),
    .o_count_error (write_count)
  );

  corebus_outstanding_table u_outstanding_table (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_cmd_fire  (cmd_fire),
    .i_cmd       (i_cmd),
    .i_resp_fire (resp_fire),
    .i_resp      (i_resp),
    .o_known     (resp_known),
    .o_expected  (resp_expected)
  );

  corebus_response_checker u_response_checker (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_resp_fire   (resp_fire),
    .i_resp        (i_resp),
    .i_known       (resp_known),
    .i_expected    (resp_expected),
    .o_unknown     (resp_unknown),
    .o_count_error (resp_count)
  );

  always_comb begin
    err_now              = '0;
    err_now.hold_cmd     = hold_cmd;
    err_now.hold_data    = hold_data;
    err_now.hold_resp    = hold_resp;
    err_now.write_count  = write_count;
    err_now.resp_unknown = resp_unknown;
    err_now.resp_count   = resp_count;
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_err        <= '0;
      o_err_status <= '0;
    end else begin
      o_err <= err_now;  // one pulse per violating edge.
      if (i_clr_status) begin
        o_err_status <= err_now;  // new errors survive a clear.
      end else begin
        o_err_status <= corebus_pkg::corebus_err_t'(o_err_status | err_now);
      end
    end
  end

endmodule

`default_nettype wire

/* src/corebus_outstanding_table.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// corebus outstanding table
// per-id record of non-posted commands
// and their expected response beats.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module corebus_outstanding_table (
  input  var logic                        clk,
  input  var logic                        i_rst_n,
  input  var logic                        i_cmd_fire,
  input  var corebus_pkg::corebus_cmd_t   i_cmd,
  input  var logic                        i_resp_fire,
  input  var corebus_pkg::corebus_resp_t  i_resp,
  output logic                            o_known,
  output logic [corebus_pkg::BEAT_W-1:0]  o_expected
);

  logic [2**corebus_pkg::ID_W-1:0] busy;
  corebus_pkg::corebus_resp_e      kind  [2**corebus_pkg::ID_W];
  logic [corebus_pkg::BEAT_W-1:0]  beats [2**corebus_pkg::ID_W];
  logic                            is_read;
  logic                            record;
  corebus_pkg::corebus_resp_e      cmd_kind;
  logic [corebus_pkg::BEAT_W-1:0]  cmd_beats;

  assign is_read = (i_cmd.kind == corebus_pkg::COREBUS_READ);

  // posted writes and busy ids are not recorded.
  assign record = i_cmd_fire && (i_cmd.kind != corebus_pkg::COREBUS_WRITE) &&
                  !busy[i_cmd.id];

  assign cmd_kind  = is_read ? corebus_pkg::COREBUS_RESP_DATA : corebus_pkg::COREBUS_RESP;
  assign cmd_beats = is_read ? corebus_pkg::burst_beats(i_cmd.len)
                             : corebus_pkg::BEAT_W'(1);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy <= '0;
    end else begin
      if (i_resp_fire && i_resp.last) begin
        busy[i_resp.id] <= 1'b0;  // burst done.
      end
      if (record) begin
        busy[i_cmd.id] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (record) begin
      kind[i_cmd.id]  <= cmd_kind;
      beats[i_cmd.id] <= cmd_beats;
    end
  end

  // lookup by response id, kind must match too.
  assign o_known    = busy[i_resp.id] && (kind[i_resp.id] == i_resp.kind);
  assign o_expected = beats[i_resp.id];

endmodule

`default_nettype wire

/* src/corebus_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// corebus package
// bus widths, encodings and the payload
// and error structs of the core bus monitor.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package corebus_pkg;

  localparam int ID_W      = 3;
  localparam int LEN_W     = 4;   // 0 encodes MAX_BEATS.
  localparam int MAX_BEATS = 16;
  localparam int BEAT_W    = 5;
  localparam int DATA_W    = 32;
  localparam int ADDR_W    = 16;
  localparam int WQ_DEPTH  = 4;
  localparam int WQ_PTR_W  = $clog2(WQ_DEPTH);

  typedef enum logic [1:0] {
    COREBUS_READ     = 2'd0,  // non-posted, returns data.
    COREBUS_WRITE    = 2'd1,  // posted.
    COREBUS_WRITE_NP = 2'd2   // non-posted, single response beat.
  } corebus_cmd_e;

  typedef enum logic {
    COREBUS_RESP      = 1'b0,
    COREBUS_RESP_DATA = 1'b1
  } corebus_resp_e;

  typedef struct packed {
    corebus_cmd_e      kind;
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } corebus_cmd_t;

  typedef struct packed {
    logic [DATA_W-1:0]   data;
    logic [DATA_W/8-1:0] be;
    logic                last;
  } corebus_wdata_t;

  typedef struct packed {
    corebus_resp_e     kind;
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic              last;
  } corebus_resp_t;

  typedef struct packed {
    logic hold_cmd;
    logic hold_data;
    logic hold_resp;
    logic write_count;
    logic resp_unknown;
    logic resp_count;
  } corebus_err_t;

  // length field to beat count.
  function automatic logic [BEAT_W-1:0] burst_beats(input logic [LEN_W-1:0] len);
    logic [BEAT_W-1:0] beats;
    if (len == '0) begin
      beats = BEAT_W'(MAX_BEATS);
    end else begin
      beats = BEAT_W'(len);
    end
    return beats;
  endfunction

endpackage

`default_nettype wire

/* src/corebus_response_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// corebus response checker
// counts response beats per burst and
// flags unknown ids and bad beat counts.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module corebus_response_checker (
  input  var logic                        clk,
  input  var logic                        i_rst_n,
  input  var logic                        i_resp_fire,
  input  var corebus_pkg::corebus_resp_t  i_resp,
  input  var logic                        i_known,
  input  var logic [corebus_pkg::BEAT_W-1:0] i_expected,
  output logic                            o_unknown,
  output logic                            o_count_error
);

  logic                           in_burst;
  logic                           skip_q;
  logic [corebus_pkg::BEAT_W-1:0] cnt_q;
  logic [corebus_pkg::BEAT_W-1:0] exp_q;
  logic                           first;
  logic                           cur_skip;
  logic [corebus_pkg::BEAT_W-1:0] cur_exp;
  logic [corebus_pkg::BEAT_W-1:0] cnt_now;
  logic                           bad_count;

  assign first = !in_burst;

  // lookup taken on the first beat, held for the rest.
  assign cur_skip = first ? !i_known : skip_q;
  assign cur_exp  = first ? i_expected : exp_q;
  assign cnt_now  = (first ? '0 : cnt_q) + 1'b1;

  // last at the wrong count, or the count reached without last.
  assign bad_count = i_resp.last ? (cnt_now != cur_exp) : (cnt_now >= cur_exp);

  assign o_unknown     = i_resp_fire && first && !i_known;
  assign o_count_error = i_resp_fire && !cur_skip && bad_count;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      in_burst <= 1'b0;
      skip_q   <= 1'b0;
      cnt_q    <= '0;
    end else if (i_resp_fire) begin
      if (i_resp.last) begin
        in_burst <= 1'b0;
        skip_q   <= 1'b0;
        cnt_q    <= '0;
      end else begin
        in_burst <= 1'b1;
        skip_q   <= cur_skip;
        cnt_q    <= cnt_now;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_resp_fire && !i_resp.last) begin
      exp_q <= cur_exp;
    end
  end

endmodule

`default_nettype wire

/* src/corebus_write_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// corebus write checker
// pairs write commands with data bursts
// in order and compares length to beats.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module corebus_write_checker (
  input  var logic                        clk,
  input  var logic                        i_rst_n,
  input  var logic                        i_cmd_fire,
  input  var corebus_pkg::corebus_cmd_t   i_cmd,
  input  var logic                        i_wdata_fire,
  input  var corebus_pkg::corebus_wdata_t i_wdata,
  output logic                            o_count_error
);

  // queue 0 holds command lengths, queue 1 finished burst counts.
  logic [1:0]                     q_push;
  logic [1:0]                     q_avail;
  logic [corebus_pkg::BEAT_W-1:0] q_in   [2];
  logic [corebus_pkg::BEAT_W-1:0] q_head [2];
  logic                           pair;
  logic [corebus_pkg::BEAT_W-1:0] beat_cnt;

  assign q_push[0] = i_cmd_fire && (i_cmd.kind != corebus_pkg::COREBUS_READ);
  assign q_in[0]   = corebus_pkg::burst_beats(i_cmd.len);
  assign q_push[1] = i_wdata_fire && i_wdata.last;
  assign q_in[1]   = beat_cnt + 1'b1;

  for (genvar g = 0; g < 2; g++) begin : g_queue
    logic [corebus_pkg::BEAT_W-1:0]   mem [corebus_pkg::WQ_DEPTH];
    logic [corebus_pkg::WQ_PTR_W-1:0] rd_ptr;
    logic [corebus_pkg::WQ_PTR_W-1:0] wr_ptr;
    logic [corebus_pkg::WQ_PTR_W:0]   count;
    logic                             empty;
    logic                             full;
    logic                             store;
    logic                             pop;

    assign empty = (count == '0);
    assign full  = (count == (corebus_pkg::WQ_PTR_W + 1)'(corebus_pkg::WQ_DEPTH));

    // an arrival into an empty queue can be consumed at once.
    assign q_avail[g] = !empty || q_push[g];
    assign q_head[g]  = empty ? q_in[g] : mem[rd_ptr];

    assign pop   = pair && !empty;
    assign store = q_push[g] && !(pair && empty) && !full;

    always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        rd_ptr <= '0;
        wr_ptr <= '0;
        count  <= '0;
      end else begin
        if (store) begin
          wr_ptr <= wr_ptr + 1'b1;
        end
        if (pop) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
        count <= count + (corebus_pkg::WQ_PTR_W + 1)'(store)
                       - (corebus_pkg::WQ_PTR_W + 1)'(pop);
      end
    end

    always_ff @(posedge clk) begin
      if (store) begin
        mem[wr_ptr] <= q_in[g];
      end
    end
  end

  assign pair          = &q_avail;
  assign o_count_error = pair && (q_head[0] != q_head[1]);

  // beats of the burst in flight.
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      beat_cnt <= '0;
    end else if (i_wdata_fire) begin
      beat_cnt <= i_wdata.last ? '0 : beat_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire
